// ==== sim.f ====
rtl/uart_pkg.sv
rtl/uart_rx.sv
rtl/uart_tx.sv
rtl/uart_regs.sv
rtl/uart_top.sv
dv/uart_tb.sv

// ==== Bender.yml ====
package:
  name: uart

sources:
  - rtl/uart_pkg.sv
  - rtl/uart_rx.sv
  - rtl/uart_tx.sv
  - rtl/uart_regs.sv
  - rtl/uart_top.sv
  - target: simulation
    files:
      - dv/uart_tb.sv

// ==== dv/uart_tb.sv ====
// Directed testbench for uart_top; runs bus, loopback, parity, overrun and bus error tests
`timescale 1ns/1ps

module uart_tb;

    localparam int SPB         = 8;
    localparam int CLK_PERIOD  = 8;
    localparam int NBYTES      = 4;                  // Random bytes per loopback mode
    localparam int FRAME_COUNT = 6 * NBYTES + 4;
    localparam int TEST_COUNT  = 5;
    localparam int MAX_FRAME   = 12 * SPB;           // Longest frame in cycles
    localparam int POLL_LIMIT  = 4 * MAX_FRAME;
    localparam longint WATCHDOG_NS = longint'(FRAME_COUNT) * MAX_FRAME * CLK_PERIOD
                                     * TEST_COUNT * 4;

    logic clk_sample, rst;
    logic awvalid, wvalid, bready, arvalid, rready;
    logic awready, wready, bvalid, arready, rvalid;
    logic [3:0] wstrb;
    uart_pkg::axi_addr_t awaddr, araddr;
    uart_pkg::axi_data_t wdata, rdata;
    uart_pkg::axi_resp_t bresp, rresp;
    logic tx, rx_drv, loop_sel, tb_rx;
    int   errors = 0;
    int   checks = 0;
    int   seed   = 32'h1571_c11b;

    assign tb_rx = loop_sel ? tx : rx_drv;  // Loopback or driven line

    uart_top #(.SAMPLES_PER_BIT(SPB)) dut (
        .clk_sample(clk_sample), .rst(rst),
        .awvalid(awvalid), .awaddr(awaddr), .awready(awready),
        .wvalid(wvalid), .wdata(wdata), .wstrb(wstrb), .wready(wready),
        .bvalid(bvalid), .bresp(bresp), .bready(bready),
        .arvalid(arvalid), .araddr(araddr), .arready(arready),
        .rvalid(rvalid), .rdata(rdata), .rresp(rresp), .rready(rready),
        .tx(tx), .rx(tb_rx)
    );

    initial begin
        clk_sample = 1'b0;
        forever #(CLK_PERIOD / 2) clk_sample = ~clk_sample;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired, the simulation appears to hang");
        $display("test failed");
        $finish;
    end

    task automatic compare_data(input string name, input uart_pkg::axi_data_t got,
                                input uart_pkg::axi_data_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic compare_resp(input string name, input uart_pkg::axi_resp_t got,
                                input uart_pkg::axi_resp_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0t: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic compare_byte(input string name, input uart_pkg::uart_byte_t got,
                                input uart_pkg::uart_byte_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic compare_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0t: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic report_timeout(input string what);
        errors++;
        $display("timed out at %0t waiting for %s", $time, what);
    endtask

    // Parity bit that makes data ones plus this bit even or odd
    function automatic logic expected_parity(input uart_pkg::uart_byte_t b, input int mode);
        int ones;
        ones = 0;
        for (int i = 0; i < 8; i++) begin
            ones += b[i];
        end
        return (mode == 2) ? ((ones % 2) == 0) : ((ones % 2) == 1);
    endfunction

    task automatic axi_write(input uart_pkg::axi_addr_t addr, input uart_pkg::axi_data_t data,
                             output uart_pkg::axi_resp_t resp);
        int n;
        n = 0;
        @(negedge clk_sample);
        awvalid = 1'b1;
        wvalid  = 1'b1;
        awaddr  = addr;
        wdata   = data;
        wstrb   = 4'hF;
        do begin
            @(negedge clk_sample);
            n++;
        end while (!awready && n < POLL_LIMIT);
        if (awready) begin
            compare_bit("wready", wready, 1'b1);  // Both ready signals rise together
        end
        @(negedge clk_sample);  // Handshake completed on the rising edge in between
        awvalid = 1'b0;
        wvalid  = 1'b0;
        while (!bvalid && n < POLL_LIMIT) begin
            @(negedge clk_sample);
            n++;
        end
        if (n >= POLL_LIMIT) begin
            report_timeout("the write response");
        end
        resp = bresp;
    endtask

    task automatic axi_read(input uart_pkg::axi_addr_t addr, output uart_pkg::axi_data_t data,
                            output uart_pkg::axi_resp_t resp);
        int n;
        n = 0;
        @(negedge clk_sample);
        arvalid = 1'b1;
        araddr  = addr;
        do begin
            @(negedge clk_sample);
            n++;
        end while (!arready && n < POLL_LIMIT);
        @(negedge clk_sample);
        arvalid = 1'b0;
        while (!rvalid && n < POLL_LIMIT) begin
            @(negedge clk_sample);
            n++;
        end
        if (n >= POLL_LIMIT) begin
            report_timeout("the read data");
        end
        data = rdata;
        resp = rresp;
    endtask

    // Polls STATUS until the chosen bit reaches the wanted level
    task automatic wait_status(input int idx, input logic level);
        uart_pkg::axi_data_t d;
        uart_pkg::axi_resp_t r;
        int n;
        n = 0;
        do begin
            axi_read(uart_pkg::REG_STATUS, d, r);
            n++;
        end while (d[idx] !== level && n < POLL_LIMIT);
        if (n >= POLL_LIMIT) begin
            report_timeout($sformatf("STATUS bit %0d", idx));
        end
    endtask

    task automatic sample_frame(input uart_pkg::uart_byte_t b, input int mode, input logic two);
        int n;
        n = 0;
        while (tx !== 1'b0 && n < POLL_LIMIT) begin
            @(negedge clk_sample);
            n++;
        end
        if (n >= POLL_LIMIT) begin
            report_timeout("a start bit on tx");
            return;
        end
        repeat (SPB / 2) @(negedge clk_sample);  // Middle of the start bit
        compare_bit("tx start", tx, 1'b0);
        for (int i = 0; i < 8; i++) begin
            repeat (SPB) @(negedge clk_sample);
            compare_bit($sformatf("tx data[%0d]", i), tx, b[i]);
        end
        if (mode == 1 || mode == 2) begin
            repeat (SPB) @(negedge clk_sample);
            compare_bit("tx parity", tx, expected_parity(b, mode));
        end
        repeat (SPB) @(negedge clk_sample);
        compare_bit("tx stop", tx, 1'b1);
        if (two) begin
            repeat (SPB) @(negedge clk_sample);
            compare_bit("tx second stop", tx, 1'b1);
        end
    endtask

    task automatic send_frame(input uart_pkg::uart_byte_t b, input int mode, input logic two,
                              input logic flip);
        @(negedge clk_sample);
        loop_sel = 1'b0;
        rx_drv   = 1'b0;
        repeat (SPB) @(negedge clk_sample);
        for (int i = 0; i < 8; i++) begin
            rx_drv = b[i];
            repeat (SPB) @(negedge clk_sample);
        end
        if (mode == 1 || mode == 2) begin
            rx_drv = expected_parity(b, mode) ^ flip;
            repeat (SPB) @(negedge clk_sample);
        end
        rx_drv = 1'b1;
        repeat (two ? 2 * SPB : SPB) @(negedge clk_sample);
    endtask

    task automatic finish_test(input string name, input int err_before);
        $display("%s: %0d errors", name, errors - err_before);
    endtask

    task automatic test_reset();
        uart_pkg::axi_data_t d;
        uart_pkg::axi_resp_t r;
        int e;
        e = errors;
        compare_bit("tx", tx, 1'b1);
        compare_bit("wready", wready, 1'b0);
        axi_read(uart_pkg::REG_STATUS, d, r);
        compare_data("STATUS", d, 32'h0);
        compare_resp("rresp", r, uart_pkg::RESP_OKAY);
        axi_read(uart_pkg::REG_CTRL, d, r);
        compare_data("CTRL", d, 32'h0);
        compare_resp("rresp", r, uart_pkg::RESP_OKAY);
        finish_test("reset", e);
    endtask

    task automatic test_loopback();
        uart_pkg::axi_data_t  d;
        uart_pkg::axi_resp_t  r;
        uart_pkg::uart_byte_t b;
        int e;
        e = errors;
        loop_sel = 1'b1;
        for (int mode = 0; mode < 3; mode++) begin
            for (int two = 0; two < 2; two++) begin
                axi_write(uart_pkg::REG_CTRL, (two << uart_pkg::CTRL_TWO_STOP) | mode, r);
                compare_resp("bresp", r, uart_pkg::RESP_OKAY);
                for (int k = 0; k < NBYTES; k++) begin
                    b = $random(seed);
                    axi_write(uart_pkg::REG_TXDATA, {24'h0, b}, r);
                    compare_resp("bresp", r, uart_pkg::RESP_OKAY);
                    sample_frame(b, mode, two[0]);
                    wait_status(uart_pkg::ST_RX_VALID, 1'b1);
                    axi_read(uart_pkg::REG_RXDATA, d, r);
                    compare_byte("RXDATA", d[7:0], b);
                    axi_read(uart_pkg::REG_STATUS, d, r);
                    compare_data("STATUS", d, 32'h0);
                end
            end
        end
        finish_test("loopback", e);
    endtask

    task automatic test_parity_error();
        uart_pkg::axi_data_t d;
        uart_pkg::axi_resp_t r;
        int e;
        e = errors;
        axi_write(uart_pkg::REG_CTRL, 32'h1, r);  // Even parity, one stop bit
        send_frame(8'h5A, 1, 1'b0, 1'b1);
        wait_status(uart_pkg::ST_PARITY_ERR, 1'b1);
        axi_read(uart_pkg::REG_STATUS, d, r);
        compare_data("STATUS", d, 32'h1 << uart_pkg::ST_PARITY_ERR);
        axi_write(uart_pkg::REG_STATUS, 32'h1 << uart_pkg::ST_PARITY_ERR, r);
        axi_read(uart_pkg::REG_STATUS, d, r);
        compare_data("STATUS", d, 32'h0);
        finish_test("parity error", e);
    endtask

    task automatic test_overrun();
        uart_pkg::axi_data_t d;
        uart_pkg::axi_resp_t r;
        int e;
        e = errors;
        axi_write(uart_pkg::REG_CTRL, 32'h0, r);
        send_frame(8'hC3, 0, 1'b0, 1'b0);
        send_frame(8'h3C, 0, 1'b0, 1'b0);
        wait_status(uart_pkg::ST_OVERRUN, 1'b1);
        axi_read(uart_pkg::REG_RXDATA, d, r);
        compare_byte("RXDATA", d[7:0], 8'hC3);
        axi_read(uart_pkg::REG_STATUS, d, r);
        compare_data("STATUS", d, 32'h1 << uart_pkg::ST_OVERRUN);
        axi_write(uart_pkg::REG_STATUS, 32'h1 << uart_pkg::ST_OVERRUN, r);
        finish_test("overrun", e);
    endtask

    task automatic test_bus_errors();
        uart_pkg::axi_data_t d;
        uart_pkg::axi_resp_t r, r2;
        int e;
        e = errors;
        axi_read(4'h2, d, r);
        compare_resp("rresp unmapped", r, uart_pkg::RESP_SLVERR);
        axi_write(4'h6, 32'h0, r);
        compare_resp("bresp unmapped", r, uart_pkg::RESP_SLVERR);
        loop_sel = 1'b1;
        axi_write(uart_pkg::REG_TXDATA, 32'hA5, r);
        compare_resp("bresp", r, uart_pkg::RESP_OKAY);
        fork
            sample_frame(8'hA5, 0, 1'b0);
            begin
                axi_write(uart_pkg::REG_TXDATA, 32'h0F, r2);
                compare_resp("bresp busy", r2, uart_pkg::RESP_SLVERR);
                axi_read(uart_pkg::REG_STATUS, d, r2);
                compare_bit("STATUS tx_busy", d[uart_pkg::ST_TX_BUSY], 1'b1);
            end
        join
        wait_status(uart_pkg::ST_RX_VALID, 1'b1);
        axi_read(uart_pkg::REG_RXDATA, d, r);
        compare_byte("RXDATA", d[7:0], 8'hA5);
        repeat (2 * MAX_FRAME) begin  // The dropped byte must never be sent
            @(negedge clk_sample);
            if (tx !== 1'b1) begin
                errors++;
                $display("tx left idle at %0t after a rejected TXDATA write", $time);
                break;
            end
        end
        finish_test("bus errors", e);
    endtask

    initial begin
        rst      = 1'b0;
        awvalid  = 1'b0;
        wvalid   = 1'b0;
        awaddr   = '0;
        wdata    = '0;
        wstrb    = '0;
        bready   = 1'b1;
        arvalid  = 1'b0;
        araddr   = '0;
        rready   = 1'b1;
        rx_drv   = 1'b1;
        loop_sel = 1'b0;
        repeat (4) @(negedge clk_sample);
        rst = 1'b1;
        test_reset();
        test_loopback();
        test_parity_error();
        test_overrun();
        test_bus_errors();
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// ==== rtl/uart_top.sv ====
// UART top level; joins the AXI4-Lite register block with the transmitter and receiver
`timescale 1ns/1ps

module uart_top #(
    parameter int SAMPLES_PER_BIT = 8  // Power of two, at least 4
) (
    input  logic                clk_sample,
    input  logic                rst,
    input  logic                awvalid,
    input  uart_pkg::axi_addr_t awaddr,
    output logic                awready,
    input  logic                wvalid,
    input  uart_pkg::axi_data_t wdata,
    input  logic [3:0]          wstrb,
    output logic                wready,
    output logic                bvalid,
    output uart_pkg::axi_resp_t bresp,
    input  logic                bready,
    input  logic                arvalid,
    input  uart_pkg::axi_addr_t araddr,
    output logic                arready,
    output logic                rvalid,
    output uart_pkg::axi_data_t rdata,
    output uart_pkg::axi_resp_t rresp,
    input  logic                rready,
    output logic                tx,
    input  logic                rx
);

    logic                   tx_start, tx_busy, two_stop;
    logic                   rx_done, rx_parity_err;
    uart_pkg::uart_byte_t   tx_data, rx_data;
    uart_pkg::parity_mode_t parity_mode;

    uart_regs u_regs (
        .clk_sample(clk_sample), .rst(rst),
        .awvalid(awvalid), .awaddr(awaddr), .awready(awready),
        .wvalid(wvalid), .wdata(wdata), .wstrb(wstrb), .wready(wready),
        .bvalid(bvalid), .bresp(bresp), .bready(bready),
        .arvalid(arvalid), .araddr(araddr), .arready(arready),
        .rvalid(rvalid), .rdata(rdata), .rresp(rresp), .rready(rready),
        .tx_start(tx_start), .tx_data(tx_data),
        .parity_mode(parity_mode), .two_stop(two_stop),
        .tx_busy(tx_busy), .rx_data(rx_data),
        .rx_done(rx_done), .rx_parity_err(rx_parity_err)
    );

    uart_tx #(.SAMPLES_PER_BIT(SAMPLES_PER_BIT)) u_tx (
        .clk_sample(clk_sample), .rst(rst),
        .tx_start(tx_start), .tx_data(tx_data),
        .parity_mode(parity_mode), .two_stop(two_stop),
        .tx(tx), .tx_busy(tx_busy)
    );

    uart_rx #(.SAMPLES_PER_BIT(SAMPLES_PER_BIT)) u_rx (
        .clk_sample(clk_sample), .rst(rst), .rx(rx),
        .parity_mode(parity_mode), .two_stop(two_stop),
        .rx_data(rx_data), .rx_done(rx_done), .rx_parity_err(rx_parity_err)
    );

endmodule

// ==== rtl/uart_regs.sv ====
// AXI4-Lite register block holding TXDATA, RXDATA, STATUS and CTRL for the UART
`timescale 1ns/1ps

module uart_regs (
    input  logic                   clk_sample,
    input  logic                   rst,
    input  logic                   awvalid,
    input  uart_pkg::axi_addr_t    awaddr,
    output logic                   awready,
    input  logic                   wvalid,
    input  uart_pkg::axi_data_t    wdata,
    input  logic [3:0]             wstrb,
    output logic                   wready,
    output logic                   bvalid,
    output uart_pkg::axi_resp_t    bresp,
    input  logic                   bready,
    input  logic                   arvalid,
    input  uart_pkg::axi_addr_t    araddr,
    output logic                   arready,
    output logic                   rvalid,
    output uart_pkg::axi_data_t    rdata,
    output uart_pkg::axi_resp_t    rresp,
    input  logic                   rready,
    output logic                   tx_start,
    output uart_pkg::uart_byte_t   tx_data,
    output uart_pkg::parity_mode_t parity_mode,
    output logic                   two_stop,
    input  logic                   tx_busy,
    input  uart_pkg::uart_byte_t   rx_data,
    input  logic                   rx_done,
    input  logic                   rx_parity_err
);

    uart_pkg::uart_byte_t rx_byte;
    uart_pkg::axi_data_t  status;
    uart_pkg::axi_data_t  ctrl;
    uart_pkg::axi_data_t  rd_data;
    logic                 rx_valid, parity_err, overrun;
    logic                 wr_fire, rd_fire;
    logic                 wr_err, rd_err;
    logic                 wr_tx, wr_status, wr_ctrl;
    logic                 rx_read, rx_accept;

    assign wr_fire   = awready && awvalid && wvalid;
    assign rd_fire   = arready && arvalid;
    assign wr_tx     = wr_fire && wstrb[0] && !wr_err && (awaddr == uart_pkg::REG_TXDATA);
    assign wr_status = wr_fire && wstrb[0] && (awaddr == uart_pkg::REG_STATUS);
    assign wr_ctrl   = wr_fire && wstrb[0] && (awaddr == uart_pkg::REG_CTRL);
    assign rx_read   = rd_fire && (araddr == uart_pkg::REG_RXDATA);
    assign rx_accept = rx_done && (!rx_valid || rx_read);  // Freed slot takes the new byte

    always_comb begin
        case (awaddr)
            uart_pkg::REG_TXDATA: wr_err = tx_busy || tx_start;  // One byte in flight at most
            uart_pkg::REG_RXDATA,
            uart_pkg::REG_STATUS,
            uart_pkg::REG_CTRL:   wr_err = 1'b0;
            default:              wr_err = 1'b1;
        endcase
    end

    always_comb begin
        status = '0;
        status[uart_pkg::ST_RX_VALID]   = rx_valid;
        status[uart_pkg::ST_TX_BUSY]    = tx_busy;
        status[uart_pkg::ST_PARITY_ERR] = parity_err;
        status[uart_pkg::ST_OVERRUN]    = overrun;
        ctrl = '0;
        ctrl[uart_pkg::CTRL_PARITY_LSB +: 2] = parity_mode;
        ctrl[uart_pkg::CTRL_TWO_STOP]        = two_stop;
        rd_err = 1'b0;
        case (araddr)
            uart_pkg::REG_RXDATA: rd_data = {24'b0, rx_byte};
            uart_pkg::REG_STATUS: rd_data = status;
            uart_pkg::REG_CTRL:   rd_data = ctrl;
            default: begin
                rd_data = '0;  // TXDATA is write only
                rd_err  = (araddr != uart_pkg::REG_TXDATA);
            end
        endcase
    end

    always_ff @(posedge clk_sample or negedge rst) begin
        if (!rst) begin
            awready     <= 1'b0;
            wready      <= 1'b0;
            bvalid      <= 1'b0;
            bresp       <= uart_pkg::RESP_OKAY;
            arready     <= 1'b0;
            rvalid      <= 1'b0;
            rresp       <= uart_pkg::RESP_OKAY;
            tx_start    <= 1'b0;
            parity_mode <= uart_pkg::PARITY_NONE;
            two_stop    <= 1'b0;
            rx_valid    <= 1'b0;
            parity_err  <= 1'b0;
            overrun     <= 1'b0;
        end else begin
            // A held response blocks the next request
            awready  <= awvalid && wvalid && !bvalid && !awready;
            wready   <= awvalid && wvalid && !bvalid && !awready;
            arready  <= arvalid && !rvalid && !arready;
            tx_start <= wr_tx;
            if (wr_fire) begin
                bvalid <= 1'b1;
                bresp  <= wr_err ? uart_pkg::RESP_SLVERR : uart_pkg::RESP_OKAY;
            end else if (bready) begin
                bvalid <= 1'b0;
            end
            if (rd_fire) begin
                rvalid <= 1'b1;
                rresp  <= rd_err ? uart_pkg::RESP_SLVERR : uart_pkg::RESP_OKAY;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
            if (wr_ctrl) begin
                parity_mode <= wdata[uart_pkg::CTRL_PARITY_LSB +: 2];
                two_stop    <= wdata[uart_pkg::CTRL_TWO_STOP];
            end
            if (rx_accept) begin
                rx_valid <= 1'b1;
            end else if (rx_read) begin
                rx_valid <= 1'b0;
            end
            // Setting wins over a clear in the same cycle
            if (rx_parity_err) begin
                parity_err <= 1'b1;
            end else if (wr_status && wdata[uart_pkg::ST_PARITY_ERR]) begin
                parity_err <= 1'b0;
            end
            if (rx_done && !rx_accept) begin
                overrun <= 1'b1;  // Byte discarded, the unread one is kept
            end else if (wr_status && wdata[uart_pkg::ST_OVERRUN]) begin
                overrun <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_sample) begin
        if (wr_tx) begin
            tx_data <= wdata[7:0];
        end
        if (rx_accept) begin
            rx_byte <= rx_data;
        end
        if (rd_fire) begin
            rdata <= rd_data;
        end
    end

endmodule

// ==== rtl/uart_tx.sv ====
// UART transmitter; sends one byte with optional parity and one or two stop bits
`timescale 1ns/1ps

module uart_tx #(
    parameter int SAMPLES_PER_BIT = 8
) (
    input  logic                   clk_sample,
    input  logic                   rst,
    input  logic                   tx_start,
    input  uart_pkg::uart_byte_t   tx_data,
    input  uart_pkg::parity_mode_t parity_mode,
    input  logic                   two_stop,
    output logic                   tx,
    output logic                   tx_busy
);

    localparam int CW = $clog2(SAMPLES_PER_BIT);

    uart_pkg::tx_state_e  state;
    uart_pkg::uart_byte_t tx_byte;   // Byte latched at the start of the frame
    logic [CW-1:0]        win_cnt;
    logic [2:0]           bit_idx;
    logic [2:0]           next_idx;
    logic                 stop_idx;
    logic                 win_end;
    logic                 parity_on;
    logic                 parity_bit;

    assign win_end    = (win_cnt == CW'(SAMPLES_PER_BIT - 1));
    assign next_idx   = bit_idx + 3'd1;
    assign parity_on  = (parity_mode == uart_pkg::PARITY_EVEN) ||
                        (parity_mode == uart_pkg::PARITY_ODD);
    // Same rule as the receiver: data ones plus this bit give the chosen total
    assign parity_bit = (parity_mode == uart_pkg::PARITY_ODD) ? ~(^tx_byte) : ^tx_byte;

    always_ff @(posedge clk_sample or negedge rst) begin
        if (!rst) begin
            state    <= uart_pkg::TX_IDLE;
            win_cnt  <= '0;
            bit_idx  <= '0;
            stop_idx <= 1'b0;
            tx       <= 1'b1;
            tx_busy  <= 1'b0;
        end else begin
            if (state != uart_pkg::TX_IDLE) begin
                win_cnt <= win_cnt + 1'b1;
            end
            case (state)
                uart_pkg::TX_IDLE: begin
                    if (tx_start) begin
                        state   <= uart_pkg::TX_START;
                        win_cnt <= '0;
                        tx      <= 1'b0;  // Start bit
                        tx_busy <= 1'b1;
                    end
                end
                uart_pkg::TX_START: begin
                    if (win_end) begin
                        state   <= uart_pkg::TX_DATA;
                        bit_idx <= '0;
                        tx      <= tx_byte[0];
                    end
                end
                uart_pkg::TX_DATA: begin
                    if (win_end) begin
                        bit_idx <= next_idx;
                        if (bit_idx == 3'd7) begin
                            if (parity_on) begin
                                state <= uart_pkg::TX_PARITY;
                                tx    <= parity_bit;
                            end else begin
                                state    <= uart_pkg::TX_STOP;
                                stop_idx <= 1'b0;
                                tx       <= 1'b1;
                            end
                        end else begin
                            tx <= tx_byte[next_idx];
                        end
                    end
                end
                uart_pkg::TX_PARITY: begin
                    if (win_end) begin
                        state    <= uart_pkg::TX_STOP;
                        stop_idx <= 1'b0;
                        tx       <= 1'b1;
                    end
                end
                uart_pkg::TX_STOP: begin
                    if (win_end) begin
                        stop_idx <= 1'b1;
                        if (!two_stop || stop_idx) begin
                            state   <= uart_pkg::TX_IDLE;  // Line stays high
                            tx_busy <= 1'b0;
                        end
                    end
                end
                default: state <= uart_pkg::TX_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_sample) begin
        if (state == uart_pkg::TX_IDLE && tx_start) begin
            tx_byte <= tx_data;
        end
    end

endmodule

// ==== rtl/uart_rx.sv ====
// Oversampling UART receiver; majority votes each bit window and checks parity
`timescale 1ns/1ps

module uart_rx #(
    parameter int SAMPLES_PER_BIT = 8
) (
    input  logic                  clk_sample,
    input  logic                  rst,
    input  logic                  rx,
    input  uart_pkg::parity_mode_t parity_mode,
    input  logic                  two_stop,
    output uart_pkg::uart_byte_t  rx_data,
    output logic                  rx_done,
    output logic                  rx_parity_err
);

    localparam int CW = $clog2(SAMPLES_PER_BIT);

    logic                 rx_s1, rx_s2;    // Two flop synchronizer
    logic                 rx_prev;         // Previous synchronized level for edge detect
    uart_pkg::rx_state_e  state;
    logic [CW-1:0]        win_cnt;         // Sample position inside the bit window
    logic [CW:0]          ones_cnt;        // High samples seen so far in this window
    logic [CW:0]          ones_next;
    logic [2:0]           bit_idx;
    logic                 stop_idx;
    logic                 par_acc;         // Running XOR of received data bits
    logic                 win_end;
    logic                 win_bit;
    logic                 parity_on;
    logic                 parity_ok;
    uart_pkg::uart_byte_t rx_shift;

    assign win_end   = (win_cnt == CW'(SAMPLES_PER_BIT - 1));
    assign ones_next = ones_cnt + {{CW{1'b0}}, rx_s2};  // Includes the current sample
    assign win_bit   = (ones_next > (CW+1)'(SAMPLES_PER_BIT / 2));  // Majority of the window
    assign parity_on = (parity_mode == uart_pkg::PARITY_EVEN) ||
                       (parity_mode == uart_pkg::PARITY_ODD);
    // Data ones plus parity bit must give an even or odd total
    assign parity_ok = (parity_mode == uart_pkg::PARITY_ODD) ? (par_acc ^ win_bit)
                                                             : ~(par_acc ^ win_bit);
    assign rx_data   = rx_shift;

    always_ff @(posedge clk_sample or negedge rst) begin
        if (!rst) begin
            rx_s1   <= 1'b1;  // Line idles high
            rx_s2   <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_s1   <= rx;
            rx_s2   <= rx_s1;
            rx_prev <= rx_s2;
        end
    end

    always_ff @(posedge clk_sample or negedge rst) begin
        if (!rst) begin
            state         <= uart_pkg::RX_IDLE;
            win_cnt       <= '0;
            ones_cnt      <= '0;
            bit_idx       <= '0;
            stop_idx      <= 1'b0;
            par_acc       <= 1'b0;
            rx_done       <= 1'b0;
            rx_parity_err <= 1'b0;
        end else begin
            rx_done       <= 1'b0;  // Both strobes are single cycle
            rx_parity_err <= 1'b0;
            if (state != uart_pkg::RX_IDLE) begin
                win_cnt <= win_cnt + 1'b1;  // Wraps at the window end
            end
            if (state == uart_pkg::RX_DATA || state == uart_pkg::RX_PARITY) begin
                ones_cnt <= win_end ? '0 : ones_next;
            end
            case (state)
                uart_pkg::RX_IDLE: begin
                    if (rx_prev && !rx_s2) begin
                        state   <= uart_pkg::RX_START;
                        win_cnt <= CW'(1);  // The detecting sample belongs to the start window
                    end
                end
                uart_pkg::RX_START: begin
                    if (win_end) begin
                        state   <= uart_pkg::RX_DATA;
                        bit_idx <= '0;
                        par_acc <= 1'b0;
                    end
                end
                uart_pkg::RX_DATA: begin
                    if (win_end) begin
                        par_acc <= par_acc ^ win_bit;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state    <= parity_on ? uart_pkg::RX_PARITY : uart_pkg::RX_STOP;
                            stop_idx <= 1'b0;
                        end
                    end
                end
                uart_pkg::RX_PARITY: begin
                    if (win_end) begin
                        if (parity_ok) begin
                            state <= uart_pkg::RX_STOP;
                        end else begin
                            state         <= uart_pkg::RX_IDLE;  // Frame is dropped
                            rx_parity_err <= 1'b1;
                        end
                    end
                end
                uart_pkg::RX_STOP: begin
                    // Stop level is not checked, only its length is waited out
                    if (win_end) begin
                        stop_idx <= 1'b1;
                        if (!two_stop || stop_idx) begin
                            state   <= uart_pkg::RX_IDLE;
                            rx_done <= 1'b1;
                        end
                    end
                end
                default: state <= uart_pkg::RX_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_sample) begin
        if (state == uart_pkg::RX_DATA && win_end) begin
            rx_shift <= {win_bit, rx_shift[7:1]};  // LSB arrives first
        end
    end

endmodule

// ==== rtl/uart_pkg.sv ====
// Shared widths, parity codes, register map and FSM state types used by every UART block
package uart_pkg;

    typedef logic [7:0]  uart_byte_t;    // One character
    typedef logic [1:0]  parity_mode_t;  // Parity setting from CTRL
    typedef logic [3:0]  axi_addr_t;     // Byte address inside the register block
    typedef logic [31:0] axi_data_t;
    typedef logic [1:0]  axi_resp_t;

    localparam parity_mode_t PARITY_NONE = 2'd0;
    localparam parity_mode_t PARITY_EVEN = 2'd1;
    localparam parity_mode_t PARITY_ODD  = 2'd2;  // Code 3 is treated as none

    localparam axi_resp_t RESP_OKAY   = 2'b00;
    localparam axi_resp_t RESP_SLVERR = 2'b10;

    localparam axi_addr_t REG_TXDATA = 4'h0;
    localparam axi_addr_t REG_RXDATA = 4'h4;
    localparam axi_addr_t REG_STATUS = 4'h8;
    localparam axi_addr_t REG_CTRL   = 4'hC;

    // STATUS bit positions
    localparam int ST_RX_VALID   = 0;
    localparam int ST_TX_BUSY    = 1;
    localparam int ST_PARITY_ERR = 2;  // Sticky, write one to clear
    localparam int ST_OVERRUN    = 3;  // Sticky, write one to clear

    // CTRL bit positions
    localparam int CTRL_PARITY_LSB = 0;  // Two bit parity field
    localparam int CTRL_TWO_STOP   = 2;

    typedef enum logic [2:0] {
        RX_IDLE, RX_START, RX_DATA, RX_PARITY, RX_STOP
    } rx_state_e;

    typedef enum logic [2:0] {
        TX_IDLE, TX_START, TX_DATA, TX_PARITY, TX_STOP
    } tx_state_e;

endpackage
